/* tests/uart_testdata.mem */
// Columns: operation, byte or offset, expected value, all hex
// Ops 1 send, 2 receive, 3 status, 4 poll status, 5 read response, 6 banged frame, 7 rx select, 0 end
3 00 006  // Status after reset
1 A5 000
1 3C 000
2 00 0A5
2 00 03C
7 01 000  // Receiver on the banged line
6 5A 000  // Stop bit low
2 00 15A
6 81 001
2 00 081
7 00 000  // Back to loopback
1 11 000
1 22 000
1 33 000
1 44 000
1 55 000  // Dropped, receive FIFO full
4 00 01A  // Full and overrun
3 00 00A  // Overrun cleared by the read before
2 00 011
2 00 022
2 00 033
2 00 044
3 00 006
5 0C 002  // Unmapped offset
0 00 000

/* project.f */
verilog/uart_pkg.sv
verilog/sync_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_core.sv
verilog/uart_axil.sv
tests/tb_uart_props.sv
tests/tb_uart.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := tb_uart
FILELIST  := project.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
DATA      := tests/uart_testdata.mem
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM) $(DATA)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Result: PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/tb_uart.sv */
`default_nettype none

module tb_uart;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_FREQUENCY = 50_000_000;
    localparam int BAUD_RATE       = 5_000_000;
    localparam int FIFO_DEPTH      = 4;
    localparam int DIV             = CLOCK_FREQUENCY / BAUD_RATE; // Clock cycles per bit
    localparam int FRAME_NS        = 10 * DIV * 20;                 // One 8N1 frame
    localparam int MAX_RECORDS     = 64;
    localparam int POLL_LIMIT      = 200;                           // Status reads per wait
    localparam int BUS_LIMIT       = 20;                            // Cycles per handshake

    logic        clock;
    logic        reset;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        rready;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        uart_rxd;
    logic        uart_txd;
    logic        rx_select;                     // High routes the banged line to the receiver
    logic        bang_line;                     // Serial line driven by the testbench
    logic [15:0] testdata [3 * MAX_RECORDS];    // Op, argument, expected per record
    int          record_count;
    logic        records_loaded;
    int          errors;

    assign uart_rxd = rx_select ? bang_line : uart_txd; // Loopback unless selected

    uart_axil #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY),
        .BAUD_RATE       (BAUD_RATE),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // 12 frame times per record plus margin for reset
    initial begin
        wait (records_loaded);
        #(record_count * 12 * FRAME_NS + 20_000);
        $display("Watchdog expired, the run did not finish %0d records in time", record_count);
        $display("Checked %0d records, %0d errors", record_count, errors);
        $display("Result: FAILED");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        int wait_count;
        wait_count = 0;
        @(negedge clock);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;                                 // Address a cycle ahead of data
        @(negedge clock);
        if (awready !== 1'b0) report_mismatch("awready", 32'(awready), 32'h0);
        if (wready !== 1'b0) report_mismatch("wready", 32'(wready), 32'h0);
        if (bvalid !== 1'b0) report_mismatch("bvalid", 32'(bvalid), 32'h0);
        wvalid = 1'b1;
        @(negedge clock);
        while (!bvalid && wait_count < BUS_LIMIT) begin // bvalid marks the accept
            wait_count++;
            @(negedge clock);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) begin
            errors++;
            $display("Write to offset 0x%0h got no response", addr);
        end
        if (bresp !== 2'b00) report_mismatch("bresp", 32'(bresp), 32'h0);
        @(negedge clock);                               // Response left waiting a cycle
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int wait_count;
        wait_count = 0;
        @(negedge clock);
        if (arready !== 1'b1) report_mismatch("arready", 32'(arready), 32'h1); // Nothing pending
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clock);
        while (!rvalid && wait_count < BUS_LIMIT) begin
            wait_count++;
            @(negedge clock);
        end
        arvalid = 1'b0;
        if (!rvalid) begin
            errors++;
            $display("Read of offset 0x%0h got no response", addr);
        end else if (arready !== 1'b0) begin
            report_mismatch("arready", 32'(arready), 32'h0); // One read outstanding
        end
        data   = rdata;
        resp   = rresp;
        @(negedge clock);                               // Response left waiting a cycle
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
    endtask

    // Polls STATUS until the masked bits match
    task automatic wait_status(input logic [31:0] mask, input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        bus_read(uart_pkg::ADDR_STATUS, data, resp);
        while ((data & mask) !== expected && polls < POLL_LIMIT) begin
            polls++;
            bus_read(uart_pkg::ADDR_STATUS, data, resp);
        end
        if ((data & mask) !== expected) report_mismatch("status", data & mask, expected);
    endtask

    // Samples uart_txd mid-bit from the falling start edge
    task automatic capture_frame(output logic [9:0] bits);
        int i;
        @(negedge uart_txd);
        repeat (DIV / 2) @(negedge clock);
        for (i = 0; i < 10; i++) begin
            bits[i] = uart_txd;
            if (i < 9) begin
                repeat (DIV) @(negedge clock);
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] bits;
        fork
            capture_frame(bits);
            bus_write(uart_pkg::ADDR_TXDATA, {24'd0, value});
        join
        if (bits[0] !== 1'b0) report_mismatch("uart_txd start bit", 32'(bits[0]), 32'h0);
        if (bits[8:1] !== value) report_mismatch("uart_txd data", 32'(bits[8:1]), 32'(value));
        if (bits[9] !== 1'b1) report_mismatch("uart_txd stop bit", 32'(bits[9]), 32'h1);
    endtask

    task automatic receive_byte(input logic [8:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        wait_status(32'h1 << uart_pkg::ST_RX_EMPTY, 32'h0); // Something to read
        bus_read(uart_pkg::ADDR_RXDATA, data, resp);
        if (data !== {23'd0, expected}) report_mismatch("rdata", data, {23'd0, expected});
        if (resp !== 2'b00) report_mismatch("rresp", 32'(resp), 32'h0);
    endtask

    task automatic bang_frame(input logic [7:0] value, input logic stop_level);
        logic [9:0] bits;
        int         i;
        bits = {stop_level, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(negedge clock);
            bang_line = bits[i];
            repeat (DIV - 1) @(negedge clock);
        end
        @(negedge clock);
        bang_line = 1'b1;
        repeat (DIV) @(negedge clock); // One idle bit before anything else
    endtask

    initial begin
        int          index;
        logic [15:0] op;
        logic [15:0] arg;
        logic [15:0] expected;
        logic [31:0] data;
        logic [1:0]  resp;
        reset          = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        rx_select      = 1'b0;
        bang_line      = 1'b1;
        errors         = 0;
        records_loaded = 1'b0;
        $readmemh("tests/uart_testdata.mem", testdata);
        record_count = 0;
        while (record_count < MAX_RECORDS && !$isunknown(testdata[3 * record_count])
               && testdata[3 * record_count] != 16'h0) begin
            record_count++;
        end
        records_loaded = 1'b1;
        if (record_count == 0) begin
            errors++;
            $display("No records found in the data file");
        end
        repeat (4) @(negedge clock);  // 4 rising edges in reset
        reset = 1'b0;
        if (uart_txd !== 1'b1) report_mismatch("uart_txd", 32'(uart_txd), 32'h1);
        if (bvalid !== 1'b0) report_mismatch("bvalid", 32'(bvalid), 32'h0);
        if (rvalid !== 1'b0) report_mismatch("rvalid", 32'(rvalid), 32'h0);
        for (index = 0; index < record_count; index++) begin
            op       = testdata[3 * index];
            arg      = testdata[3 * index + 1];
            expected = testdata[3 * index + 2];
            case (op)
                16'h1: send_byte(arg[7:0]);
                16'h2: receive_byte(expected[8:0]);
                16'h3: begin
                    bus_read(uart_pkg::ADDR_STATUS, data, resp);
                    if (data !== {16'd0, expected}) report_mismatch("status", data,
                                                                    {16'd0, expected});
                end
                16'h4: wait_status(32'hFFFF_FFFF, {16'd0, expected});
                16'h5: begin
                    bus_read(arg[3:0], data, resp);
                    if (resp !== expected[1:0]) report_mismatch("rresp", 32'(resp),
                                                                32'(expected[1:0]));
                end
                16'h6: bang_frame(arg[7:0], expected[0]);
                16'h7: rx_select = arg[0];
                default: begin
                    errors++;
                    $display("Record %0d has an unknown operation 0x%0h", index, op);
                end
            endcase
        end
        $display("Checked %0d records, %0d errors", record_count, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_uart_props.sv */
`default_nettype none

module tb_uart_props (
    input wire logic       clock,
    input wire logic       reset,
    input wire logic       awvalid,
    input wire logic       awready,
    input wire logic [3:0] awaddr,
    input wire logic       bvalid,
    input wire logic       bready,
    input wire logic [1:0] bresp,
    input wire logic       arvalid,
    input wire logic       arready,
    input wire logic [3:0] araddr,
    input wire logic       rvalid,
    input wire logic       rready,
    input wire logic [1:0] rresp,
    input wire logic       uart_txd,
    input wire logic       tx_empty,
    input wire logic       tx_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    function automatic logic mapped(input logic [3:0] addr);
        return (addr == uart_pkg::ADDR_TXDATA) || (addr == uart_pkg::ADDR_RXDATA) ||
               (addr == uart_pkg::ADDR_STATUS);
    endfunction

    // Valid stays up until its handshake
    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before handshake");
    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before handshake");
    a_b_hold: assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
    a_r_hold: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

    // Mapped offsets answer OKAY
    a_bresp_okay: assert property (@(posedge clock) disable iff (reset)
        awvalid && awready && mapped(awaddr) |=> bresp == 2'b00)
        else $error("bresp not OKAY for a mapped offset");
    a_rresp_okay: assert property (@(posedge clock) disable iff (reset)
        arvalid && arready && mapped(araddr) |=> rresp == 2'b00)
        else $error("rresp not OKAY for a mapped offset");

    // Line idles high with nothing to send
    a_txd_idle: assert property (@(posedge clock) disable iff (reset)
        tx_empty && !tx_busy |-> uart_txd) else $error("uart_txd low while idle");

endmodule

bind uart_axil tb_uart_props i_props (
    .clock (clock), .reset (reset),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
    .bvalid (bvalid), .bready (bready), .bresp (bresp),
    .arvalid (arvalid), .arready (arready), .araddr (araddr),
    .rvalid (rvalid), .rready (rready), .rresp (rresp),
    .uart_txd (uart_txd), .tx_empty (tx_empty), .tx_busy (u_core.u_tx.busy)
);

`default_nettype wire

/* verilog/uart_axil.sv */
`default_nettype none

module uart_axil #(
    parameter int CLOCK_FREQUENCY = 50_000_000,
    parameter int BAUD_RATE       = 115_200,
    parameter int FIFO_DEPTH      = 16
) (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic [3:0]  awaddr,
    input  wire logic        awvalid,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0]  wstrb,
    input  wire logic        wvalid,
    input  wire logic        bready,
    input  wire logic [3:0]  araddr,
    input  wire logic        arvalid,
    input  wire logic        rready,
    output logic             awready,
    output logic             wready,
    output logic             bvalid,
    output logic [1:0]       bresp,
    output logic             arready,
    output logic             rvalid,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    input  wire logic        uart_rxd,
    output logic             uart_txd
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                write_accept;  // Address and data taken together
    logic                read_accept;
    logic                tx_write;
    logic                rx_pop;
    logic                status_read;
    logic                overrun_flag;  // Sticky
    logic [31:0]         status_word;
    logic [31:0]         read_word;
    uart_pkg::rx_entry_t rx_head;
    logic                tx_full;
    logic                tx_empty;
    logic                rx_empty;
    logic                rx_full;
    logic                rx_overrun;
    logic                rx_busy;

    function automatic logic is_mapped(input logic [3:0] addr);
        return (addr == uart_pkg::ADDR_TXDATA) || (addr == uart_pkg::ADDR_RXDATA) ||
               (addr == uart_pkg::ADDR_STATUS);
    endfunction

    // Write needs both channels and no response pending
    assign write_accept = awvalid && wvalid && !bvalid;
    assign awready      = write_accept;
    assign wready       = write_accept;
    assign arready      = !rvalid;      // One read outstanding
    assign read_accept  = arvalid && arready;

    assign tx_write    = write_accept && (awaddr == uart_pkg::ADDR_TXDATA) && wstrb[0];
    assign rx_pop      = read_accept && (araddr == uart_pkg::ADDR_RXDATA);
    assign status_read = read_accept && (araddr == uart_pkg::ADDR_STATUS);

    always_comb begin
        status_word                        = '0;
        status_word[uart_pkg::ST_TX_FULL]  = tx_full;
        status_word[uart_pkg::ST_TX_EMPTY] = tx_empty;
        status_word[uart_pkg::ST_RX_EMPTY] = rx_empty;
        status_word[uart_pkg::ST_RX_FULL]  = rx_full;
        status_word[uart_pkg::ST_OVERRUN]  = overrun_flag;
        status_word[uart_pkg::ST_RX_BUSY]  = rx_busy;
    end

    always_comb begin
        case (araddr)
            uart_pkg::ADDR_RXDATA: read_word = rx_empty ? '0 : {23'd0, rx_head}; // Stale head hidden
            uart_pkg::ADDR_STATUS: read_word = status_word;
            default:               read_word = '0;   // TXDATA reads as zero
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
            overrun_flag <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (write_accept) begin
                bvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (read_accept) begin
                rvalid <= 1'b1;
            end
            // A new overrun wins over the clear
            if (rx_overrun) begin
                overrun_flag <= 1'b1;
            end else if (status_read) begin
                overrun_flag <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clock) begin
        if (write_accept) begin
            bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (read_accept) begin
            rdata <= read_word;
            rresp <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    uart_core #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY),
        .BAUD_RATE       (BAUD_RATE),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) u_core (
        .clock      (clock),
        .reset      (reset),
        .tx_write   (tx_write),
        .tx_byte    (wdata[7:0]),
        .rx_pop     (rx_pop),
        .uart_rxd   (uart_rxd),
        .rx_head    (rx_head),
        .tx_full    (tx_full),
        .tx_empty   (tx_empty),
        .rx_empty   (rx_empty),
        .rx_full    (rx_full),
        .rx_overrun (rx_overrun),
        .rx_busy    (rx_busy),
        .uart_txd   (uart_txd)
    );

endmodule

`default_nettype wire

/* verilog/uart_core.sv */
`default_nettype none

module uart_core #(
    parameter int CLOCK_FREQUENCY = 50_000_000,
    parameter int BAUD_RATE       = 115_200,
    parameter int FIFO_DEPTH      = 16
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          tx_write,
    input  wire logic [7:0]    tx_byte,
    input  wire logic          rx_pop,
    input  wire logic          uart_rxd,
    output uart_pkg::rx_entry_t rx_head,
    output logic               tx_full,
    output logic               tx_empty,
    output logic               rx_empty,
    output logic               rx_full,
    output logic               rx_overrun,
    output logic               rx_busy,
    output logic               uart_txd
);

    logic                tx_fifo_read;   // Serializer takes the head
    logic [7:0]          tx_fifo_data;
    logic                rx_entry_valid; // Deserializer push strobe
    uart_pkg::rx_entry_t rx_entry;

    // Character dropped because the receive FIFO had no room
    assign rx_overrun = rx_entry_valid && rx_full;

    sync_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (logic [7:0])
    ) u_tx_fifo (
        .clock    (clock),
        .reset    (reset),
        .write_en (tx_write),
        .data_in  (tx_byte),
        .read_en  (tx_fifo_read),
        .data_out (tx_fifo_data),
        .full     (tx_full),
        .empty    (tx_empty)
    );

    uart_tx #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY),
        .BAUD_RATE       (BAUD_RATE)
    ) u_tx (
        .clock      (clock),
        .reset      (reset),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_fifo_data),
        .fifo_read  (tx_fifo_read),
        .txd        (uart_txd)
    );

    uart_rx #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY),
        .BAUD_RATE       (BAUD_RATE)
    ) u_rx (
        .clock       (clock),
        .reset       (reset),
        .rxd         (uart_rxd),
        .entry_valid (rx_entry_valid),
        .entry       (rx_entry),
        .busy        (rx_busy)
    );

    sync_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (uart_pkg::rx_entry_t)
    ) u_rx_fifo (
        .clock    (clock),
        .reset    (reset),
        .write_en (rx_entry_valid), // Ignored by the FIFO when full
        .data_in  (rx_entry),
        .read_en  (rx_pop),
        .data_out (rx_head),
        .full     (rx_full),
        .empty    (rx_empty)
    );

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`default_nettype none

module uart_rx #(
    parameter int CLOCK_FREQUENCY = 50_000_000,
    parameter int BAUD_RATE       = 115_200
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          rxd,
    output logic               entry_valid,
    output uart_pkg::rx_entry_t entry,
    output logic               busy
);

    localparam logic [15:0] DIVISOR = uart_pkg::baud_divisor(CLOCK_FREQUENCY, BAUD_RATE);

    logic        rxd_meta;    // First synchronizer stage
    logic        rxd_sync;    // Safe to use
    logic        rxd_prev;    // Last synchronized sample for edge detect
    logic [15:0] baud_count;
    logic [3:0]  bit_index;   // 0 start, 1 to 8 data, 9 stop
    logic [7:0]  shift_reg;   // Data bits arrive LSB first
    logic        start_edge;
    logic        sample_tick; // Middle of the current bit

    // Falling edge only, so a held low line after a bad frame is not a new start
    assign start_edge  = !busy && rxd_prev && !rxd_sync;
    assign sample_tick = busy && (baud_count == DIVISOR - 16'd1);

    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy        <= 1'b0;
            baud_count  <= '0;
            bit_index   <= '0;
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= 1'b0;                 // Single cycle push strobe
            if (start_edge) begin
                busy       <= 1'b1;
                baud_count <= DIVISOR >> 1;      // Half bit preload lands samples mid-bit
                bit_index  <= '0;
            end else if (sample_tick) begin
                baud_count <= '0;
                bit_index  <= bit_index + 4'd1;
                if (bit_index == 4'd0 && rxd_sync) begin
                    busy <= 1'b0;                // Start bit gone high, glitch
                end else if (bit_index == 4'd9) begin
                    busy        <= 1'b0;
                    entry_valid <= 1'b1;         // Pushed even with a framing error
                end
            end else if (busy) begin
                baud_count <= baud_count + 16'd1;
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clock) begin
        if (sample_tick && bit_index >= 4'd1 && bit_index <= 4'd8) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};
        end
        if (sample_tick && bit_index == 4'd9) begin
            entry.data        <= shift_reg;
            entry.frame_error <= !rxd_sync;     // Stop bit must be high
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter int CLOCK_FREQUENCY = 50_000_000,
    parameter int BAUD_RATE       = 115_200
) (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       fifo_empty,
    input  wire logic [7:0] fifo_data,
    output logic            fifo_read,
    output logic            txd
);

    localparam logic [15:0] DIVISOR = uart_pkg::baud_divisor(CLOCK_FREQUENCY, BAUD_RATE);

    logic [15:0] baud_count; // Cycles spent in the current bit
    logic [9:0]  shift_reg;  // Stop, data, start with bit 0 on the line
    logic [3:0]  bit_index;  // Bit of the frame now on the line
    logic        busy;       // Frame in progress

    // Load and pop happen together on the same edge
    assign fifo_read = !busy && !fifo_empty;
    assign txd       = shift_reg[0]; // Straight from a flop so no glitches

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            shift_reg  <= '1;    // Line idles high
            baud_count <= '0;
            bit_index  <= '0;
        end else if (fifo_read) begin
            busy       <= 1'b1;
            shift_reg  <= {1'b1, fifo_data, 1'b0}; // 8N1 frame
            baud_count <= '0;
            bit_index  <= '0;
        end else if (busy) begin
            if (baud_count == DIVISOR - 16'd1) begin
                baud_count <= '0;
                shift_reg  <= {1'b1, shift_reg[9:1]}; // Ones fill in behind
                if (bit_index == 4'd9) begin
                    busy <= 1'b0;                     // Stop bit done
                end else begin
                    bit_index <= bit_index + 4'd1;
                end
            end else begin
                baud_count <= baud_count + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     write_en,
    input  wire payload_t data_in,
    input  wire logic     read_en,
    output payload_t      data_out,
    output logic          full,
    output logic          empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width

    payload_t      mem [DEPTH];  // Storage, no reset needed
    logic [AW-1:0] wr_ptr;       // Next slot to write
    logic [AW-1:0] rd_ptr;       // Current head
    logic [AW:0]   count;        // Entries held, 0 to DEPTH
    logic          do_write;
    logic          do_read;

    assign full     = (count == (AW + 1)'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = write_en && !full;  // Write into a full FIFO is dropped
    assign do_read  = read_en && !empty;  // Read of an empty FIFO is ignored
    assign data_out = mem[rd_ptr];        // First word falls through

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                // Wrap by compare so any depth works
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Register byte offsets on the bus
    localparam logic [3:0] ADDR_TXDATA = 4'h0; // Write pushes a byte for transmit
    localparam logic [3:0] ADDR_RXDATA = 4'h4; // Read pops the receive FIFO
    localparam logic [3:0] ADDR_STATUS = 4'h8; // Read clears the sticky overrun

    // Status word bit positions
    localparam int ST_TX_FULL  = 0; // Transmit FIFO cannot take a byte
    localparam int ST_TX_EMPTY = 1; // Nothing waiting for the serializer
    localparam int ST_RX_EMPTY = 2; // No received character to read
    localparam int ST_RX_FULL  = 3; // Next frame will be dropped
    localparam int ST_OVERRUN  = 4; // Sticky until STATUS is read
    localparam int ST_RX_BUSY  = 5; // Deserializer inside a frame

    // One received character as stored in the receive FIFO
    typedef struct packed {
        logic       frame_error; // Stop bit sampled low
        logic [7:0] data;        // First bit on the line ends up in bit 0
    } rx_entry_t;

    // Clock cycles per serial bit
    function automatic logic [15:0] baud_divisor(input int unsigned clock_frequency,
                                                 input int unsigned baud_rate);
        return 16'(clock_frequency / baud_rate);
    endfunction

endpackage

`default_nettype wire
